// ==== tb.f ====
logic/csr_pkg.sv
logic/csr_access.sv
logic/csr_counters.sv
logic/csr_machine.sv
logic/csr_unit.sv
dv/csr_unit_sva.sv
dv/csr_unit_tb.sv

// ==== dv/csr_unit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_unit_tb;

    import csr_pkg::*;

    localparam csr_data_t HART_ID     = 32'd5;
    localparam csr_data_t MTVEC_RESET = 32'h8000_0100;

    typedef struct packed {
        csr_resp_t resp;
        csr_trap_t trap;
        logic      skip_rdata;
    } expect_t;

    logic      i_clk;
    logic      i_reset;
    csr_req_t  i_req;
    csr_resp_t o_resp;
    csr_trap_t o_trap;
    csr_data_t o_ret_addr;

    logic [31:0] lfsr;
    expect_t     exp_q[$];
    csr_data_t   rdata_log[$];
    int          n_checks;
    int          n_errors;

    // Shadow copies of the architectural state.
    csr_data_t m_mstatus;
    csr_data_t m_mtvec;
    csr_data_t m_mscratch;
    csr_data_t m_mepc;
    csr_data_t m_mcause;
    csr_cntr_t m_instret;

    csr_unit
    #(
        .HART_ID     (HART_ID),
        .MTVEC_RESET (MTVEC_RESET)
    )
    DUT
    (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_req      (i_req),
        .o_resp     (o_resp),
        .o_trap     (o_trap),
        .o_ret_addr (o_ret_addr)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    function automatic logic rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic csr_data_t rand_bits(input int n);
        csr_data_t v;
        v = '0;
        for (int i = 0; i < n; i++)
            v = {v[30:0], rand_bit()};
        return v;
    endfunction

    function automatic csr_data_t op_result(input csr_data_t old_value, input csr_data_t wval,
                                            input csr_op_t op);
        if (op == CSR_OP_WRITE)
            return wval;
        if (op == CSR_OP_SET)
            return old_value | wval;
        if (op == CSR_OP_CLEAR)
            return old_value & ~wval;
        return old_value;
    endfunction

    // Reference model. Steps the shadow state by one driven cycle.
    function automatic expect_t predict(input csr_req_t req);
        expect_t   e;
        csr_data_t wval;
        logic      known;
        logic      wop;
        e = '0;
        if (req.retire)
            m_instret = m_instret + 64'd1;
        wval = req.imm_sel ? {27'd0, req.imm} : req.reg_data;
        wop = (req.op != CSR_OP_READ);
        known = 1'b1;
        case (req.idx)
            CSR_MSTATUS:  e.resp.rdata = m_mstatus;
            CSR_MTVEC:    e.resp.rdata = m_mtvec;
            CSR_MSCRATCH: e.resp.rdata = m_mscratch;
            CSR_MEPC:     e.resp.rdata = m_mepc;
            CSR_MCAUSE:   e.resp.rdata = m_mcause;
            CSR_MHARTID:  e.resp.rdata = HART_ID;
            CSR_INSTRET:  e.resp.rdata = m_instret[31:0];
            CSR_INSTRETH: e.resp.rdata = m_instret[63:32];
            CSR_CYCLE, CSR_CYCLEH: e.skip_rdata = 1'b1;
            default:      known = 1'b0;
        endcase
        e.resp.valid = 1'b1;
        e.resp.illegal = !req.ebreak && (!known || (req.idx[11:10] == 2'b11 && wop));
        // An illegal access reads as zero.
        if (e.resp.illegal)
        begin
            e.resp.rdata = '0;
            e.skip_rdata = 1'b0;
        end
        e.trap.trap = req.ebreak;
        e.trap.trap_pc = m_mtvec;
        if (req.ebreak)
        begin
            m_mepc = req.pc & ~32'd3;
            m_mcause = 32'd3;
            m_mstatus = {m_mstatus[3], 4'd0, 3'd0} & 32'h88;
        end
        else if (!e.resp.illegal && wop)
        begin
            case (req.idx)
                CSR_MSTATUS:  m_mstatus = op_result(m_mstatus, wval, req.op) & 32'h88;
                CSR_MTVEC:    m_mtvec = op_result(m_mtvec, wval, req.op) & ~32'd3;
                CSR_MSCRATCH: m_mscratch = op_result(m_mscratch, wval, req.op);
                CSR_MEPC:     m_mepc = op_result(m_mepc, wval, req.op) & ~32'd3;
                CSR_MCAUSE:   m_mcause = op_result(m_mcause, wval, req.op);
                default:      ;
            endcase
        end
        return e;
    endfunction

    function automatic csr_req_t access_req(input csr_idx_t idx, input csr_op_t op,
                                            input csr_data_t data, input logic imm_sel);
        csr_req_t r;
        r = '0;
        r.valid = 1'b1;
        r.idx = idx;
        r.op = op;
        r.imm_sel = imm_sel;
        r.imm = data[4:0];
        r.reg_data = data;
        return r;
    endfunction

    function automatic csr_req_t idle_req(input logic retire);
        csr_req_t r;
        r = '0;
        r.retire = retire;
        return r;
    endfunction

    task automatic drive(input csr_req_t req);
        expect_t e;
        @(posedge i_clk);
        #2;
        i_req = req;
        e = predict(req);
        if (req.valid)
            exp_q.push_back(e);
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 20)
        begin
            drive(idle_req(1'b0));
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            $display("Timed out with %0d responses still outstanding", exp_q.size());
            n_errors++;
            exp_q.delete();
        end
    endtask

    task automatic check_resp(input csr_resp_t got, input csr_resp_t exp, input logic skip);
        n_checks++;
        if (got.illegal !== exp.illegal)
        begin
            $display("ERR o_resp.illegal got %h exp %h", got.illegal, exp.illegal);
            n_errors++;
        end
        if (!skip && got.rdata !== exp.rdata)
        begin
            $display("ERR o_resp.rdata got %h exp %h", got.rdata, exp.rdata);
            n_errors++;
        end
    endtask

    task automatic check_trap(input csr_trap_t got, input csr_trap_t exp);
        n_checks++;
        if (got.trap !== exp.trap || (exp.trap && got.trap_pc !== exp.trap_pc))
        begin
            $display("ERR o_trap got %h exp %h", got, exp);
            n_errors++;
        end
    endtask

    task automatic check_data(input string name, input csr_data_t got, input csr_data_t exp);
        n_checks++;
        if (got !== exp)
        begin
            $display("ERR %s got %h exp %h", name, got, exp);
            n_errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%s: %s", name, (n_errors == errors_before) ? "ok" : "failed");
    endtask

    // Responses are stable by the falling edge.
    always @(negedge i_clk)
    begin : compare
        expect_t e;
        if (o_resp.valid === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                $display("Response arrived with no request outstanding");
                n_errors++;
            end
            else
            begin
                e = exp_q.pop_front();
                check_resp(o_resp, e.resp, e.skip_rdata);
                check_trap(o_trap, e.trap);
                rdata_log.push_back(o_resp.rdata);
            end
        end
        else if (o_trap.trap === 1'b1)
        begin
            $display("Trap raised without a valid response");
            n_errors++;
        end
    end

    initial
    begin : stimulus
        csr_idx_t  op_idx[4];
        csr_idx_t  any_idx[10];
        csr_req_t  r;
        csr_idx_t  idx;
        csr_op_t   op;
        csr_data_t data;
        logic      sel;
        int        start;
        op_idx = '{CSR_MSCRATCH, CSR_MTVEC, CSR_MSTATUS, CSR_MCAUSE};
        any_idx = '{CSR_MSTATUS, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
                    CSR_MHARTID, CSR_INSTRET, CSR_INSTRETH, 12'h100, 12'h7C0};
        lfsr = 32'he90b_4d7c;
        n_checks = 0;
        n_errors = 0;
        i_req = '0;
        i_reset = 1'b1;
        m_mstatus = '0;
        m_mtvec = MTVEC_RESET & ~32'd3;
        m_mscratch = '0;
        m_mepc = '0;
        m_mcause = '0;
        m_instret = '0;
        repeat (10) @(posedge i_clk);
        #2;
        i_reset = 1'b0;

        start = n_errors;
        drive(access_req(CSR_MTVEC, CSR_OP_READ, '0, 1'b0));
        drive(access_req(CSR_MHARTID, CSR_OP_READ, '0, 1'b0));
        drive(access_req(CSR_MSTATUS, CSR_OP_READ, '0, 1'b0));
        drive(access_req(CSR_MEPC, CSR_OP_READ, '0, 1'b0));
        drive(access_req(CSR_INSTRET, CSR_OP_READ, '0, 1'b0));
        wait_idle();
        report_test("reset values", start);

        start = n_errors;
        for (int i = 0; i < 32; i++)
        begin
            idx = op_idx[rand_bits(2)];
            op = csr_op_t'(1 + rand_bits(2) % 3);
            sel = rand_bit();
            data = rand_bits(32);
            drive(access_req(idx, op, data, sel));
            drive(access_req(idx, CSR_OP_READ, '0, 1'b0));
        end
        wait_idle();
        report_test("operations", start);

        start = n_errors;
        drive(access_req(CSR_CYCLE, CSR_OP_WRITE, 32'hFFFF_FFFF, 1'b0));
        drive(access_req(CSR_INSTRET, CSR_OP_SET, 32'h0000_00FF, 1'b0));
        drive(access_req(CSR_MHARTID, CSR_OP_WRITE, 32'h0000_0011, 1'b1));
        drive(access_req(12'h100, CSR_OP_READ, '0, 1'b0));
        drive(access_req(12'h7C0, CSR_OP_SET, 32'h1234_5678, 1'b0));
        drive(access_req(CSR_INSTRET, CSR_OP_READ, '0, 1'b0));
        drive(access_req(CSR_MHARTID, CSR_OP_READ, '0, 1'b0));
        wait_idle();
        report_test("illegal accesses", start);

        start = n_errors;
        for (int i = 0; i < 24; i++)
            drive(idle_req(rand_bit()));
        drive(access_req(CSR_INSTRET, CSR_OP_READ, '0, 1'b0));
        wait_idle();
        rdata_log.delete();
        drive(access_req(CSR_CYCLE, CSR_OP_READ, '0, 1'b0));
        repeat (6) drive(idle_req(1'b0));
        drive(access_req(CSR_CYCLE, CSR_OP_READ, '0, 1'b0));
        wait_idle();
        if (rdata_log.size() != 2)
        begin
            $display("Expected two cycle reads but saw %0d responses", rdata_log.size());
            n_errors++;
        end
        else
        begin
            check_data("o_resp.rdata cycle delta", rdata_log[1] - rdata_log[0], 32'd7);
        end
        report_test("retire counting", start);

        start = n_errors;
        drive(access_req(CSR_MSTATUS, CSR_OP_WRITE, 32'h0000_0008, 1'b1));
        r = access_req(CSR_MSCRATCH, CSR_OP_WRITE, rand_bits(32), 1'b0);
        r.ebreak = 1'b1;
        r.pc = rand_bits(32);
        drive(r);
        drive(access_req(CSR_MSCRATCH, CSR_OP_READ, '0, 1'b0));
        drive(access_req(CSR_MEPC, CSR_OP_READ, '0, 1'b0));
        drive(access_req(CSR_MCAUSE, CSR_OP_READ, '0, 1'b0));
        drive(access_req(CSR_MSTATUS, CSR_OP_READ, '0, 1'b0));
        wait_idle();
        check_data("o_ret_addr", o_ret_addr, m_mepc);
        report_test("trap entry", start);

        start = n_errors;
        for (int i = 0; i < 64; i++)
        begin
            idx = any_idx[rand_bits(4) % 10];
            op = csr_op_t'(rand_bits(2));
            sel = rand_bit();
            data = rand_bits(32);
            r = access_req(idx, op, data, sel);
            r.ebreak = (rand_bits(4) == 0);
            r.pc = rand_bits(32);
            r.retire = rand_bit();
            drive(r);
        end
        wait_idle();
        check_data("o_ret_addr", o_ret_addr, m_mepc);
        report_test("back-to-back requests", start);

        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/csr_unit_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_unit_sva
(
    input wire                      i_clk,
    input wire                      i_reset,
    input wire csr_pkg::csr_req_t   i_req,
    input wire csr_pkg::csr_resp_t  i_resp,
    input wire csr_pkg::csr_trap_t  i_trap
);

    // Every accepted request is answered on the next edge.
    resp_follows_req: assert property (@(posedge i_clk) disable iff (i_reset)
        i_req.valid |=> i_resp.valid)
        else $error("No response one cycle after a valid request");

    trap_needs_ebreak: assert property (@(posedge i_clk) disable iff (i_reset)
        i_trap.trap |-> $past(i_req.valid && i_req.ebreak))
        else $error("Trap without an ebreak in the previous request");

    quiet_in_reset: assert property (@(posedge i_clk)
        (i_reset && $past(i_reset)) |-> (!i_resp.valid && !i_trap.trap))
        else $error("Response or trap valid during reset");

endmodule

bind csr_unit csr_unit_sva u_sva
(
    .i_clk   (i_clk),
    .i_reset (i_reset),
    .i_req   (i_req),
    .i_resp  (o_resp),
    .i_trap  (o_trap)
);

`default_nettype wire

// ==== logic/csr_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_unit
#(
    parameter csr_pkg::csr_data_t HART_ID     = 32'd0,
    parameter csr_pkg::csr_data_t MTVEC_RESET = 32'h0000_0100
)
(
    input  wire                     i_clk,
    input  wire                     i_reset,
    input  wire csr_pkg::csr_req_t  i_req,
    output csr_pkg::csr_resp_t      o_resp,
    output csr_pkg::csr_trap_t      o_trap,
    output csr_pkg::csr_data_t      o_ret_addr
);

    import csr_pkg::*;

    csr_idx_t  idx;
    csr_wr_t   wr;
    logic      ebreak;
    csr_data_t pc;
    csr_data_t cntr_rdata;
    csr_data_t mach_rdata;

    csr_access u_access
    (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_req        (i_req),
        .i_cntr_rdata (cntr_rdata),
        .i_mach_rdata (mach_rdata),
        .o_idx        (idx),
        .o_wr         (wr),
        .o_ebreak     (ebreak),
        .o_pc         (pc),
        .o_resp       (o_resp)
    );

    csr_counters u_counters
    (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_retire (i_req.retire),
        .i_idx    (idx),
        .o_rdata  (cntr_rdata)
    );

    csr_machine
    #(
        .HART_ID     (HART_ID),
        .MTVEC_RESET (MTVEC_RESET)
    )
    u_machine
    (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_idx      (idx),
        .i_wr       (wr),
        .i_ebreak   (ebreak),
        .i_pc       (pc),
        .o_rdata    (mach_rdata),
        .o_trap     (o_trap),
        .o_ret_addr (o_ret_addr)
    );

endmodule

`default_nettype wire

// ==== logic/csr_machine.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_machine
#(
    parameter csr_pkg::csr_data_t HART_ID     = '0,
    parameter csr_pkg::csr_data_t MTVEC_RESET = '0
)
(
    input  wire                     i_clk,
    input  wire                     i_reset,
    input  wire csr_pkg::csr_idx_t  i_idx,
    input  wire csr_pkg::csr_wr_t   i_wr,
    input  wire                     i_ebreak,
    input  wire csr_pkg::csr_data_t i_pc,
    output csr_pkg::csr_data_t      o_rdata,
    output csr_pkg::csr_trap_t      o_trap,
    output csr_pkg::csr_data_t      o_ret_addr
);

    import csr_pkg::*;

    localparam csr_data_t MSTATUS_MASK = (32'd1 << MSTATUS_MIE_BIT) |
                                         (32'd1 << MSTATUS_MPIE_BIT);
    localparam csr_data_t ALIGN_MASK   = ~32'd3;

    csr_data_t mstatus_q;
    csr_data_t mtvec_q;
    csr_data_t mscratch_q;
    csr_data_t mepc_q;
    csr_data_t mcause_q;

    function automatic csr_data_t apply_op(csr_data_t old_value, csr_data_t wdata,
                                           csr_op_t op);
        csr_data_t result;
        case (op)
            CSR_OP_WRITE:
                result = wdata;
            CSR_OP_SET:
                result = old_value | wdata;
            CSR_OP_CLEAR:
                result = old_value & ~wdata;
            default:
                result = old_value;
        endcase
        return result;
    endfunction

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            mstatus_q  <= '0;
            mtvec_q    <= MTVEC_RESET & ALIGN_MASK;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end
        else
        begin
            if (i_wr.en)
            begin
                case (i_wr.idx)
                    CSR_MSTATUS:
                        mstatus_q <= apply_op(mstatus_q, i_wr.wdata, i_wr.op) & MSTATUS_MASK;
                    CSR_MTVEC:
                        mtvec_q <= apply_op(mtvec_q, i_wr.wdata, i_wr.op) & ALIGN_MASK;
                    CSR_MSCRATCH:
                        mscratch_q <= apply_op(mscratch_q, i_wr.wdata, i_wr.op);
                    CSR_MEPC:
                        mepc_q <= apply_op(mepc_q, i_wr.wdata, i_wr.op) & ALIGN_MASK;
                    CSR_MCAUSE:
                        mcause_q <= apply_op(mcause_q, i_wr.wdata, i_wr.op);
                    default:
                        ;
                endcase
            end
            // Trap entry saves the return address and stacks the interrupt enable.
            if (i_ebreak)
            begin
                mepc_q                      <= i_pc & ALIGN_MASK;
                mcause_q                    <= CAUSE_BREAKPOINT;
                mstatus_q[MSTATUS_MPIE_BIT] <= mstatus_q[MSTATUS_MIE_BIT];
                mstatus_q[MSTATUS_MIE_BIT]  <= 1'b0;
            end
        end
    end

    always_comb
    begin
        case (i_idx)
            CSR_MSTATUS:
                o_rdata = mstatus_q;
            CSR_MTVEC:
                o_rdata = mtvec_q;
            CSR_MSCRATCH:
                o_rdata = mscratch_q;
            CSR_MEPC:
                o_rdata = mepc_q;
            CSR_MCAUSE:
                o_rdata = mcause_q;
            CSR_MHARTID:
                o_rdata = HART_ID;
            default:
                o_rdata = '0;
        endcase
    end

    assign o_trap     = '{trap: i_ebreak, trap_pc: mtvec_q};
    assign o_ret_addr = mepc_q;

endmodule

`default_nettype wire

// ==== logic/csr_counters.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_counters
(
    input  wire                     i_clk,
    input  wire                     i_reset,
    input  wire                     i_retire,
    input  wire csr_pkg::csr_idx_t  i_idx,
    output csr_pkg::csr_data_t      o_rdata
);

    import csr_pkg::*;

    csr_cntr_t cycle_q;
    csr_cntr_t instret_q;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            cycle_q   <= '0;
            instret_q <= '0;
        end
        else
        begin
            cycle_q <= cycle_q + 64'd1;
            // Retire comes straight from the core, so it is counted on its own edge.
            if (i_retire)
            begin
                instret_q <= instret_q + 64'd1;
            end
        end
    end

    always_comb
    begin
        case (i_idx)
            CSR_CYCLE:
                o_rdata = cycle_q[31:0];
            CSR_CYCLEH:
                o_rdata = cycle_q[63:32];
            CSR_INSTRET:
                o_rdata = instret_q[31:0];
            CSR_INSTRETH:
                o_rdata = instret_q[63:32];
            default:
                o_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/csr_access.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_access
(
    input  wire                 i_clk,
    input  wire                 i_reset,
    input  wire csr_pkg::csr_req_t  i_req,
    input  wire csr_pkg::csr_data_t i_cntr_rdata,
    input  wire csr_pkg::csr_data_t i_mach_rdata,
    output csr_pkg::csr_idx_t   o_idx,
    output csr_pkg::csr_wr_t    o_wr,
    output logic                o_ebreak,
    output csr_pkg::csr_data_t  o_pc,
    output csr_pkg::csr_resp_t  o_resp
);

    import csr_pkg::*;

    csr_req_t  s_req;
    csr_data_t write_value;
    csr_data_t read_data;
    logic      user_level;
    logic      read_only;
    logic      write_op;
    logic      known_idx;
    logic      bad_access;
    logic      illegal;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            s_req <= '0;
        end
        else
        begin
            s_req <= i_req;
        end
    end

    assign write_value = s_req.imm_sel ? {27'd0, s_req.imm} : s_req.reg_data;

    // Bits 9:8 give the privilege level, bits 11:10 equal to 11b mark read-only.
    assign user_level    = (s_req.idx[9:8] == 2'b00);
    assign read_only     = (s_req.idx[11:10] == 2'b11);
    assign write_op      = (s_req.op != CSR_OP_READ);

    always_comb
    begin
        case (s_req.idx)
            CSR_MSTATUS, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
            CSR_MHARTID, CSR_CYCLE, CSR_INSTRET, CSR_CYCLEH, CSR_INSTRETH:
                known_idx = 1'b1;
            default:
                known_idx = 1'b0;
        endcase
    end

    assign bad_access = !known_idx || (read_only && write_op);

    // An ebreak request never writes and is never reported illegal.
    assign illegal    = s_req.valid && !s_req.ebreak && bad_access;

    // Every listed index sits at user or machine level.
    always_comb
    begin
        if (!known_idx || illegal)
            read_data = '0;
        else if (user_level)
            read_data = i_cntr_rdata;
        else
            read_data = i_mach_rdata;
    end

    assign o_wr = '{en:    s_req.valid && !s_req.ebreak && !bad_access && write_op,
                    idx:   s_req.idx,
                    op:    s_req.op,
                    wdata: write_value};

    assign o_resp = '{valid:   s_req.valid,
                      rdata:   read_data,
                      illegal: illegal};

    assign o_idx    = s_req.idx;
    assign o_ebreak = s_req.valid && s_req.ebreak;
    assign o_pc     = s_req.pc;

endmodule

`default_nettype wire

// ==== logic/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

    typedef logic [11:0] csr_idx_t;
    typedef logic [31:0] csr_data_t;
    typedef logic [63:0] csr_cntr_t;
    typedef logic [4:0]  csr_imm_t;
    typedef logic [1:0]  csr_op_t;

    localparam csr_op_t CSR_OP_READ  = 2'd0;
    localparam csr_op_t CSR_OP_WRITE = 2'd1;
    localparam csr_op_t CSR_OP_SET   = 2'd2;
    localparam csr_op_t CSR_OP_CLEAR = 2'd3;

    localparam csr_idx_t CSR_MSTATUS  = 12'h300;
    localparam csr_idx_t CSR_MTVEC    = 12'h305;
    localparam csr_idx_t CSR_MSCRATCH = 12'h340;
    localparam csr_idx_t CSR_MEPC     = 12'h341;
    localparam csr_idx_t CSR_MCAUSE   = 12'h342;
    localparam csr_idx_t CSR_MHARTID  = 12'hF14;
    localparam csr_idx_t CSR_CYCLE    = 12'hC00;
    localparam csr_idx_t CSR_INSTRET  = 12'hC02;
    localparam csr_idx_t CSR_CYCLEH   = 12'hC80;
    localparam csr_idx_t CSR_INSTRETH = 12'hC82;

    localparam csr_data_t CAUSE_BREAKPOINT = 32'd3;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // Request from the core. The source operand is reg_data unless imm_sel picks imm.
    typedef struct packed {
        logic      valid;
        csr_idx_t  idx;
        csr_op_t   op;
        logic      imm_sel;
        csr_imm_t  imm;
        csr_data_t reg_data;
        logic      ebreak;
        csr_data_t pc;
        logic      retire;
    } csr_req_t;

    typedef struct packed {
        logic      valid;
        csr_data_t rdata;
        logic      illegal;
    } csr_resp_t;

    typedef struct packed {
        logic      trap;
        csr_data_t trap_pc;
    } csr_trap_t;

    typedef struct packed {
        logic      en;
        csr_idx_t  idx;
        csr_op_t   op;
        csr_data_t wdata;
    } csr_wr_t;

endpackage

`default_nettype wire
